/* sources.f */
+incdir+common
common/alu_pkg.sv
common/alu_credit_if.sv
alu/alu.sv
src/credit_fifo.sv
alu/alu_exec.sv
src/alu_issue.sv
src/alu_subsystem_top.sv
verification/alu_checker.sv
verification/alu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := alu_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* verification/alu_tb.sv */
`include "alu_defines.svh"

bind alu_subsystem_top alu_checker checker_i (
  .clk         (clk),
  .arst_n      (arst_n),
  .credit_cnt  (issue_i.credit_cnt),
  .link_valid  (link.valid),
  .link_credit (link.credit),
  .req_full    (req_full),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .out_result  (out_result),
  .out_tag     (out_tag)
);

module alu_tb;

  localparam int W     = `ALU_WIDTH;
  localparam int OPW   = `ALU_OP_WIDTH;
  localparam int CAP   = `ALU_REQ_DEPTH + `ALU_RESP_DEPTH;  // max in flight
  localparam int N_REQ = 4 * 25 + 5 * 20 + 3 * 2 * 32 + 200 + CAP;

  logic                      clk;
  logic                      arst_n;
  logic                      in_valid;
  logic                      in_ready;
  logic [OPW-1:0]            in_op;
  logic [W-1:0]              in_src1;
  logic [W-1:0]              in_src2;
  logic [`ALU_TAG_WIDTH-1:0] in_tag;
  logic                      out_valid;
  logic                      out_ready;
  logic [W-1:0]              out_result;
  logic [`ALU_TAG_WIDTH-1:0] out_tag;

  string                     test_name = "reset";
  int                        ready_mode = 0;  // 0 always, 1 random, 2 held low
  logic [`ALU_TAG_WIDTH-1:0] next_tag = '0;
  alu_pkg::alu_resp_t        exp_q[$];

  alu_subsystem_top dut_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_op      (in_op),
    .in_src1    (in_src1),
    .in_src2    (in_src2),
    .in_tag     (in_tag),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .out_tag    (out_tag)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // expected response straight from the operation definitions
  function automatic alu_pkg::alu_resp_t alu_model(input logic [OPW-1:0] op,
      input logic [W-1:0] a, input logic [W-1:0] b, input logic [`ALU_TAG_WIDTH-1:0] tag);
    alu_pkg::alu_resp_t r;
    r.tag    = tag;
    r.result = '0;
    case (1'b1)
      op[alu_pkg::OP_ADD]:  r.result = a + b;
      op[alu_pkg::OP_SUB]:  r.result = a - b;
      op[alu_pkg::OP_SLT]:  r.result = W'($signed(a) < $signed(b));
      op[alu_pkg::OP_SLTU]: r.result = W'(a < b);
      op[alu_pkg::OP_AND]:  r.result = a & b;
      op[alu_pkg::OP_NOR]:  r.result = ~(a | b);
      op[alu_pkg::OP_OR]:   r.result = a | b;
      op[alu_pkg::OP_XOR]:  r.result = a ^ b;
      op[alu_pkg::OP_SLL]:  r.result = a << b[4:0];
      op[alu_pkg::OP_SRL]:  r.result = a >> b[4:0];
      op[alu_pkg::OP_SRA]:  r.result = $signed(a) >>> b[4:0];
      op[alu_pkg::OP_LUI]:  r.result = b;
      default:              r.result = '0;
    endcase
    return r;
  endfunction

  function automatic logic [OPW-1:0] onehot(input alu_pkg::alu_op_idx_e idx);
    return OPW'(1) << idx;
  endfunction

  function automatic logic [OPW-1:0] rand_op();
    return OPW'(1) << ($urandom % OPW);
  endfunction

  function automatic logic coin();
    logic [31:0] r;
    r = $urandom;
    return r[0];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_result(input string what, input logic [W-1:0] exp, input logic [W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_tag(input string what, input logic [`ALU_TAG_WIDTH-1:0] exp,
                           input logic [`ALU_TAG_WIDTH-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %b, actual %b",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %0d, actual %0d",
                          test_name, what, exp, act));
    end
  endtask

  // scoreboard works on the pre-edge values
  always @(posedge clk) begin
    alu_pkg::alu_resp_t want;
    if (arst_n) begin
      if (in_valid && in_ready) begin
        exp_q.push_back(alu_model(in_op, in_src1, in_src2, in_tag));
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("a result came out with no request outstanding");
        end else begin
          want = exp_q.pop_front();
          check_result("result", want.result, out_result);
          check_tag("tag", want.tag, out_tag);
        end
      end
    end
  end

  initial begin
    out_ready <= 1'b0;
    forever begin
      @(posedge clk);
      case (ready_mode)
        0:       out_ready <= 1'b1;
        1:       out_ready <= coin();
        default: out_ready <= 1'b0;
      endcase
    end
  end

  initial begin
    repeat (200 * N_REQ + 1000) @(posedge clk);
    abort_run("timeout: the DUT stopped accepting requests or returning results");
  end

  task automatic load_req(input logic [OPW-1:0] op, input logic [W-1:0] a, input logic [W-1:0] b);
    in_op   <= op;
    in_src1 <= a;
    in_src2 <= b;
    in_tag  <= next_tag;
    next_tag = next_tag + 1'b1;
  endtask

  // holds in_valid until the edge that accepts
  task automatic send_req(input logic [OPW-1:0] op, input logic [W-1:0] a, input logic [W-1:0] b);
    in_valid <= 1'b1;
    load_req(op, a, b);
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    @(posedge clk);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic run_arith();
    logic [W-1:0]         vals [5];
    alu_pkg::alu_op_idx_e ops [4];
    vals = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff};
    ops  = '{alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_SLT, alu_pkg::OP_SLTU};
    test_name = "arith";
    foreach (ops[i]) begin
      foreach (vals[j]) begin
        foreach (vals[k]) begin
          send_req(onehot(ops[i]), vals[j], vals[k]);
        end
      end
    end
    wait_drain();
  endtask

  task automatic run_logic();
    alu_pkg::alu_op_idx_e ops [5];
    ops = '{alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_NOR, alu_pkg::OP_XOR, alu_pkg::OP_LUI};
    test_name = "logic";
    foreach (ops[i]) begin
      repeat (20) send_req(onehot(ops[i]), $urandom, $urandom);
    end
    wait_drain();
  endtask

  task automatic run_shifts();
    alu_pkg::alu_op_idx_e ops [3];
    logic [W-1:0]         a;
    logic [W-1:0]         b;
    ops = '{alu_pkg::OP_SLL, alu_pkg::OP_SRL, alu_pkg::OP_SRA};
    test_name = "shifts";
    foreach (ops[i]) begin
      for (int s = 0; s < 2; s++) begin
        for (int amt = 0; amt < 32; amt++) begin
          a        = $urandom;
          a[W-1]   = s[0];      // both sign bits
          b        = $urandom;
          b[4:0]   = 5'(amt);   // upper bits must be ignored
          send_req(onehot(ops[i]), a, b);
        end
      end
    end
    wait_drain();
  endtask

  task automatic run_backpressure();
    test_name  = "backpressure";
    ready_mode = 1;
    repeat (200) begin
      repeat ($urandom % 3) @(posedge clk);  // gaps on the request side
      send_req(rand_op(), $urandom, $urandom);
    end
    wait_drain();
    ready_mode = 0;
  endtask

  task automatic run_capacity();
    int accepted;
    accepted   = 0;
    test_name  = "capacity";
    ready_mode = 2;
    @(posedge clk);
    in_valid <= 1'b1;
    load_req(rand_op(), $urandom, $urandom);
    repeat (40) begin
      @(posedge clk);
      if (in_ready) begin
        accepted++;
        load_req(rand_op(), $urandom, $urandom);
      end
    end
    in_valid <= 1'b0;
    check_count("requests accepted while blocked", CAP, accepted);
    check_flag("in_ready while blocked", 1'b0, in_ready);
    ready_mode = 0;
    wait_drain();
  endtask

  initial begin
    void'($urandom(32'he895));
    arst_n   <= 1'b0;
    in_valid <= 1'b0;
    in_op    <= '0;
    in_src1  <= '0;
    in_src2  <= '0;
    in_tag   <= '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    check_flag("out_valid after reset", 1'b0, out_valid);
    check_flag("in_ready after reset", 1'b1, in_ready);
    run_arith();
    run_logic();
    run_shifts();
    run_backpressure();
    run_capacity();
    $display("** PASS **");
    $finish;
  end

endmodule

/* verification/alu_checker.sv */
`include "alu_defines.svh"

module alu_checker (
  input logic                                  clk,
  input logic                                  arst_n,
  input logic [$clog2(`ALU_REQ_DEPTH + 1)-1:0] credit_cnt,  // issue stage counter
  input logic                                  link_valid,
  input logic                                  link_credit,
  input logic                                  req_full,
  input logic                                  out_valid,
  input logic                                  out_ready,
  input logic [`ALU_WIDTH-1:0]                 out_result,
  input logic [`ALU_TAG_WIDTH-1:0]             out_tag
);

  localparam int CNT_W = $clog2(`ALU_REQ_DEPTH + 1);

  int link_credits;  // credits left as seen on the link wires

  // one spent per valid cycle, one back per credit pulse
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      link_credits <= `ALU_REQ_DEPTH;
    end else begin
      link_credits <= link_credits - int'(link_valid) + int'(link_credit);
    end
  end

  // never more credits than request queue slots
  credit_bound_a: assert property (@(posedge clk) disable iff (!arst_n)
    credit_cnt <= CNT_W'(`ALU_REQ_DEPTH))
    else $error("credit count above request queue depth");

  // every valid cycle on the link needs a credit left over
  valid_needs_credit_a: assert property (@(posedge clk) disable iff (!arst_n)
    link_valid |-> link_credits > 0)
    else $error("link valid raised without a credit");

  // result held until the consumer takes it
  out_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_tag))
    else $error("output result changed or dropped before out_ready");

  // credits should keep the request queue from overflowing
  no_push_full_a: assert property (@(posedge clk) disable iff (!arst_n)
    link_valid |-> !req_full)
    else $error("request queue pushed while full");

endmodule

/* src/alu_subsystem_top.sv */
`include "alu_defines.svh"

module alu_subsystem_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [`ALU_OP_WIDTH-1:0]  in_op,
  input  logic [`ALU_WIDTH-1:0]     in_src1,
  input  logic [`ALU_WIDTH-1:0]     in_src2,
  input  logic [`ALU_TAG_WIDTH-1:0] in_tag,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [`ALU_WIDTH-1:0]     out_result,
  output logic [`ALU_TAG_WIDTH-1:0] out_tag
);

  alu_credit_if link ();

  alu_pkg::alu_req_t req_push_data;
  alu_pkg::alu_req_t req_head;
  logic              req_empty;
  logic              req_full;   // never set while credits are honoured
  logic              req_pop;

  alu_issue issue_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_op    (in_op),
    .in_src1  (in_src1),
    .in_src2  (in_src2),
    .in_tag   (in_tag),
    .link     (link.issue)
  );

  // link fields packed into one queue entry
  assign req_push_data = '{op: link.op, src1: link.src1, src2: link.src2, tag: link.tag};

  credit_fifo #(
    .T     (alu_pkg::alu_req_t),
    .DEPTH (`ALU_REQ_DEPTH)
  ) req_fifo_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (link.valid),
    .push_data (req_push_data),
    .pop       (req_pop),
    .pop_data  (req_head),
    .empty     (req_empty),
    .full      (req_full)
  );

  alu_exec exec_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_data   (req_head),
    .req_empty  (req_empty),
    .req_pop    (req_pop),
    .link       (link.consumer),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .out_tag    (out_tag)
  );

endmodule

/* src/alu_issue.sv */
`include "alu_defines.svh"

module alu_issue (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [`ALU_OP_WIDTH-1:0]  in_op,
  input  logic [`ALU_WIDTH-1:0]     in_src1,
  input  logic [`ALU_WIDTH-1:0]     in_src2,
  input  logic [`ALU_TAG_WIDTH-1:0] in_tag,
  alu_credit_if.issue               link
);

  localparam int CNT_W = $clog2(`ALU_REQ_DEPTH + 1);

  logic [CNT_W-1:0] credit_cnt;  // free slots in the request queue
  logic             accept;

  // one credit is enough to take a request
  assign in_ready = (credit_cnt != '0);
  assign accept   = in_valid & in_ready;

  // spend on accept so back to back requests see the new count,
  // returned credit shows up the cycle after the pulse
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= CNT_W'(`ALU_REQ_DEPTH);
    end else begin
      case ({accept, link.credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;  // none, or spend and return together
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      link.valid <= 1'b0;
    end else begin
      link.valid <= accept;
    end
  end

  // payload only moves on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      link.op   <= in_op;
      link.src1 <= in_src1;
      link.src2 <= in_src2;
      link.tag  <= in_tag;
    end
  end

endmodule

/* alu/alu_exec.sv */
`include "alu_defines.svh"

module alu_exec (
  input  logic                      clk,
  input  logic                      arst_n,
  input  alu_pkg::alu_req_t         req_data,
  input  logic                      req_empty,
  output logic                      req_pop,
  alu_credit_if.consumer            link,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [`ALU_WIDTH-1:0]     out_result,
  output logic [`ALU_TAG_WIDTH-1:0] out_tag
);

  logic [`ALU_WIDTH-1:0] alu_result;
  alu_pkg::alu_resp_t    resp_push_data;
  alu_pkg::alu_resp_t    resp_head;
  logic                  resp_empty;
  logic                  resp_full;
  logic                  resp_pop;

  // execute whenever there is work and room for the answer
  assign req_pop = ~req_empty & ~resp_full;

  // each pop frees one request queue slot
  assign link.credit = req_pop;

  alu alu_i (
    .alu_op     (req_data.op),
    .alu_src1   (req_data.src1),
    .alu_src2   (req_data.src2),
    .alu_result (alu_result)
  );

  assign resp_push_data.result = alu_result;
  assign resp_push_data.tag    = req_data.tag;

  credit_fifo #(
    .T     (alu_pkg::alu_resp_t),
    .DEPTH (`ALU_RESP_DEPTH)
  ) resp_fifo_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (req_pop),         // result lands on the same edge as the pop
    .push_data (resp_push_data),
    .pop       (resp_pop),
    .pop_data  (resp_head),
    .empty     (resp_empty),
    .full      (resp_full)
  );

  // output handshake straight off the result queue head
  assign out_valid  = ~resp_empty;
  assign resp_pop   = out_valid & out_ready;
  assign out_result = resp_head.result;
  assign out_tag    = resp_head.tag;

endmodule

/* src/credit_fifo.sv */
module credit_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic arst_n,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     pop_data,
  output logic empty,
  output logic full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T                mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            do_push;
  logic            do_pop;

  assign empty = (count == '0);
  assign full  = (count == CW'(DEPTH));

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  assign pop_data = mem[rd_ptr];  // head visible without a read strobe

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap at DEPTH-1 so any depth works
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* alu/alu.sv */
`include "alu_defines.svh"

module alu (
  input  logic [`ALU_OP_WIDTH-1:0] alu_op,
  input  logic [`ALU_WIDTH-1:0]    alu_src1,
  input  logic [`ALU_WIDTH-1:0]    alu_src2,
  output logic [`ALU_WIDTH-1:0]    alu_result
);

  localparam int W = `ALU_WIDTH;

  logic op_add;
  logic op_sub;
  logic op_slt;
  logic op_sltu;
  logic op_and;
  logic op_nor;
  logic op_or;
  logic op_xor;
  logic op_sll;
  logic op_srl;
  logic op_sra;
  logic op_lui;

  // one-hot decode
  assign op_add  = alu_op[alu_pkg::OP_ADD];
  assign op_sub  = alu_op[alu_pkg::OP_SUB];
  assign op_slt  = alu_op[alu_pkg::OP_SLT];
  assign op_sltu = alu_op[alu_pkg::OP_SLTU];
  assign op_and  = alu_op[alu_pkg::OP_AND];
  assign op_nor  = alu_op[alu_pkg::OP_NOR];
  assign op_or   = alu_op[alu_pkg::OP_OR];
  assign op_xor  = alu_op[alu_pkg::OP_XOR];
  assign op_sll  = alu_op[alu_pkg::OP_SLL];
  assign op_srl  = alu_op[alu_pkg::OP_SRL];
  assign op_sra  = alu_op[alu_pkg::OP_SRA];
  assign op_lui  = alu_op[alu_pkg::OP_LUI];

  logic           do_sub;
  logic [W-1:0]   adder_b;
  logic           adder_cin;
  logic [W-1:0]   adder_sum;
  logic           adder_cout;

  logic [W-1:0]   slt_result;
  logic [W-1:0]   sltu_result;
  logic [W-1:0]   and_result;
  logic [W-1:0]   or_result;
  logic [W-1:0]   nor_result;
  logic [W-1:0]   xor_result;
  logic [W-1:0]   sll_result;
  logic [2*W-1:0] sr_wide;
  logic [W-1:0]   sr_result;

  // shared adder, compares reuse the subtract path
  assign do_sub    = op_sub | op_slt | op_sltu;
  assign adder_b   = do_sub ? ~alu_src2 : alu_src2;
  assign adder_cin = do_sub;
  assign {adder_cout, adder_sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {{W{1'b0}}, adder_cin};

  // negative vs positive decides directly, otherwise the difference sign does
  assign slt_result = {{(W-1){1'b0}},
                       (alu_src1[W-1] & ~alu_src2[W-1])
                       | (~(alu_src1[W-1] ^ alu_src2[W-1]) & adder_sum[W-1])};

  assign sltu_result = {{(W-1){1'b0}}, ~adder_cout};  // borrow out

  assign and_result = alu_src1 & alu_src2;
  assign or_result  = alu_src1 | alu_src2;
  assign nor_result = ~or_result;
  assign xor_result = alu_src1 ^ alu_src2;

  // src1 is shifted, amount from src2[4:0]
  assign sll_result = alu_src1 << alu_src2[4:0];

  // upper half fills with the sign bit for sra only
  assign sr_wide   = {{W{op_sra & alu_src1[W-1]}}, alu_src1} >> alu_src2[4:0];
  assign sr_result = sr_wide[W-1:0];

  // and-or result select
  assign alu_result = ({W{op_add | op_sub}} & adder_sum)
                    | ({W{op_slt}}          & slt_result)
                    | ({W{op_sltu}}         & sltu_result)
                    | ({W{op_and}}          & and_result)
                    | ({W{op_nor}}          & nor_result)
                    | ({W{op_or}}           & or_result)
                    | ({W{op_xor}}          & xor_result)
                    | ({W{op_lui}}          & alu_src2)
                    | ({W{op_sll}}          & sll_result)
                    | ({W{op_srl | op_sra}} & sr_result);

endmodule

/* common/alu_credit_if.sv */
`include "alu_defines.svh"

interface alu_credit_if;

  logic                      valid;
  logic [`ALU_OP_WIDTH-1:0]  op;
  logic [`ALU_WIDTH-1:0]     src1;
  logic [`ALU_WIDTH-1:0]     src2;
  logic [`ALU_TAG_WIDTH-1:0] tag;
  logic                      credit;  // one pulse per entry freed downstream

  // producer side
  modport issue (output valid, op, src1, src2, tag, input credit);

  // request queue side
  modport queue (input valid, op, src1, src2, tag);

  // returns credits as the queue drains
  modport consumer (output credit);

endinterface

/* common/alu_pkg.sv */
`include "alu_defines.svh"

package alu_pkg;

  // bit position of each operation inside the one-hot op code
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_SLT  = 4'd2,   // signed set less than
    OP_SLTU = 4'd3,   // unsigned set less than
    OP_AND  = 4'd4,
    OP_NOR  = 4'd5,
    OP_OR   = 4'd6,
    OP_XOR  = 4'd7,
    OP_SLL  = 4'd8,
    OP_SRL  = 4'd9,
    OP_SRA  = 4'd10,
    OP_LUI  = 4'd11   // result is src2
  } alu_op_idx_e;

  // one request as it sits in the request queue
  typedef struct packed {
    logic [`ALU_OP_WIDTH-1:0]  op;
    logic [`ALU_WIDTH-1:0]     src1;
    logic [`ALU_WIDTH-1:0]     src2;
    logic [`ALU_TAG_WIDTH-1:0] tag;
  } alu_req_t;

  // one result, tag travels with it so the consumer can match it up
  typedef struct packed {
    logic [`ALU_WIDTH-1:0]     result;
    logic [`ALU_TAG_WIDTH-1:0] tag;
  } alu_resp_t;

endpackage

/* common/alu_defines.svh */
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// datapath widths
`define ALU_WIDTH      32
`define ALU_OP_WIDTH   12  // one bit per operation
`define ALU_TAG_WIDTH  4

// queue sizing
`define ALU_REQ_DEPTH  4   // also the issue stage's starting credit count
`define ALU_RESP_DEPTH 2

`endif
